// File: verilog.f
+incdir+rtl
rtl/boot_rom_pkg.sv
rtl/spi_flash_reader.sv
rtl/spram_bank.sv
rtl/rom_bank_ctrl.sv
rtl/boot_rom.sv
verif/tb_clock.sv
verif/spi_flash_model.sv
verif/boot_rom_assert.sv
verif/boot_rom_tb.sv

// File: run.sh
#!/bin/sh
# Builds the boot ROM testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module boot_rom_tb -f verilog.f > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
# Assertion errors are counted by the testbench, so the run must not stop at the first one.
./obj_dir/Vboot_rom_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
[ "$status" -eq 0 ] && ! grep -q "Some tests failed" sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }

// File: verif/boot_rom_tb.sv
`timescale 1ns/1ps

module boot_rom_tb;

  localparam int bank_aw     = 8;
  localparam int img_words   = 2 * (2 ** bank_aw);
  localparam int word_cycles = 6 * 17 + 2 + 1;  // One READ plus the idle cycle with cs high.
  localparam int copy_cycles = img_words * word_cycles;
  localparam int read_cycles = 2000;
  // The limit is twice the expected run, rounded up to the next 10,000 cycles.
  localparam int timeout_cycles = ((2 * (copy_cycles + read_cycles)) / 10000 + 1) * 10000;

  logic                    clk;
  logic                    rst;
  boot_rom_pkg::cpu_addr_t address;
  boot_rom_pkg::word_t     instruction;
  logic                    ready;
  logic                    spi_cs;
  logic                    spi_sclk;
  logic                    spi_mosi;
  logic                    spi_miso;
  int                      flash_cmds;
  int                      flash_errors;

  int                  check_errors   = 0;
  int                  monitor_errors = 0;
  int                  tests_failed   = 0;
  int                  cycle_cnt      = 0;
  int                  seed           = 32'hafb8c02f;
  logic                ready_seen     = 1'b0;
  logic                pending        = 1'b0;  // A fetch is waiting for its data.
  boot_rom_pkg::word_t pending_exp    = '0;

  tb_clock #(.period_ns(40)) clock_i (.clk(clk));

  spi_flash_model flash_i (
    .spi_cs     (spi_cs),
    .spi_sclk   (spi_sclk),
    .spi_mosi   (spi_mosi),
    .spi_miso   (spi_miso),
    .cmd_count  (flash_cmds),
    .cmd_errors (flash_errors)
  );

  boot_rom #(.bank_aw(bank_aw)) dut_i (
    .clk         (clk),
    .rst         (rst),
    .address     (address),
    .instruction (instruction),
    .ready       (ready),
    .spi_miso    (spi_miso),
    .spi_cs      (spi_cs),
    .spi_sclk    (spi_sclk),
    .spi_mosi    (spi_mosi)
  );

  bind boot_rom boot_rom_assert #(.bank_aw(bank_aw)) assert_i (
    .clk         (clk),
    .rst         (rst),
    .address     (address),
    .instruction (instruction),
    .ready       (ready),
    .spi_cs      (spi_cs),
    .spi_sclk    (spi_sclk)
  );

  function automatic boot_rom_pkg::word_t expected_word(input boot_rom_pkg::cpu_addr_t a);
    expected_word = boot_rom_pkg::word_t'(a % img_words) ^ 16'hC3A5;
  endfunction

  function automatic int error_total();
    error_total = check_errors + monitor_errors + flash_errors + dut_i.assert_i.fail_count;
  endfunction

  task automatic check_word(input string name, input boot_rom_pkg::word_t expected,
                            input boot_rom_pkg::word_t actual);
    word_ok_a: assert (actual === expected) else begin
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      check_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    bit_ok_a: assert (actual === expected) else begin
      $display("mismatch at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      check_errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_total() == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, error_total() - errors_before);
      tests_failed++;
    end
  endtask

  // Checks the data of the previous fetch, then puts the next address on the bus.
  task automatic issue_fetch(input boot_rom_pkg::cpu_addr_t a);
    @(negedge clk);
    if (pending) begin
      check_word("instruction", pending_exp, instruction);
    end
    address     = a;
    pending_exp = expected_word(a);
    pending     = 1'b1;
  endtask

  task automatic finish_fetches();
    @(negedge clk);
    if (pending) begin
      check_word("instruction", pending_exp, instruction);
    end
    pending = 1'b0;
  endtask

  // Watches the copy phase and the flash pins for the whole run.
  always @(negedge clk) begin
    if (!rst) begin
      if (!ready) begin
        loading_zero_a: assert (instruction == '0) else begin
          $display("mismatch at %0t ns: instruction expected 0000, got %h", $time, instruction);
          monitor_errors++;
        end
        ready_sticky_a: assert (!ready_seen) else begin
          $display("ready went low again at %0t ns after the copy had finished", $time);
          monitor_errors++;
        end
      end else begin
        ready_seen = 1'b1;
        cs_parked_a: assert (spi_cs) else begin
          $display("mismatch at %0t ns: spi_cs expected 1, got %b", $time, spi_cs);
          monitor_errors++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    int errors_before;
    int cmds_at_ready;
    int rnd;
    rst     = 1'b1;
    address = '0;

    // The reset state is checked in the last reset cycle and just after release.
    errors_before = error_total();
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_bit("ready", 1'b0, ready);
    check_word("instruction", 16'h0000, instruction);
    check_bit("spi_cs", 1'b1, spi_cs);
    check_bit("spi_sclk", 1'b1, spi_sclk);
    rst = 1'b0;
    @(negedge clk);
    check_bit("ready", 1'b0, ready);
    check_word("instruction", 16'h0000, instruction);
    report_test("reset_state", errors_before);

    // The monitor covers instruction and ready while the copy runs.
    errors_before = error_total();
    while (!ready) begin
      @(negedge clk);
    end
    cmd_total_a: assert (flash_cmds == img_words) else begin
      $display("mismatch at %0t ns: flash command count expected %0d, got %0d",
               $time, img_words, flash_cmds);
      check_errors++;
    end
    report_test("copy_phase", errors_before);

    // Long enough for a restarted READ to reach the command count of the flash model.
    errors_before = error_total();
    cmds_at_ready = flash_cmds;
    repeat (word_cycles) begin
      @(negedge clk);
      check_bit("spi_cs", 1'b1, spi_cs);
    end
    no_new_cmds_a: assert (flash_cmds == cmds_at_ready) else begin
      $display("the flash received a command after ready at %0t ns", $time);
      check_errors++;
    end
    report_test("flash_idle", errors_before);

    errors_before = error_total();
    for (int i = 0; i < img_words / 2; i++) begin
      issue_fetch(boot_rom_pkg::cpu_addr_t'(i));
    end
    finish_fetches();
    report_test("low_bank", errors_before);

    // Upper half first, then random addresses that keep switching banks.
    errors_before = error_total();
    for (int i = img_words / 2; i < img_words; i++) begin
      issue_fetch(boot_rom_pkg::cpu_addr_t'(i));
    end
    for (int i = 0; i < 200; i++) begin
      rnd = $random(seed);
      issue_fetch(boot_rom_pkg::cpu_addr_t'(rnd & (img_words - 1)));
    end
    finish_fetches();
    report_test("high_bank_switching", errors_before);

    repeat (2) @(negedge clk);  // Lets the last concurrent checks complete.
    $display("tests run: 5, tests failed: %0d, errors: %0d", tests_failed, error_total());
    if (tests_failed == 0 && error_total() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: verif/boot_rom_assert.sv
`timescale 1ns/1ps
`include "boot_rom_config.svh"

module boot_rom_assert #(
  parameter int bank_aw = `BOOT_ROM_BANK_AW
) (
  input logic                    clk,
  input logic                    rst,
  input boot_rom_pkg::cpu_addr_t address,
  input boot_rom_pkg::word_t     instruction,
  input logic                    ready,
  input logic                    spi_cs,
  input logic                    spi_sclk
);

  localparam int img_words = 2 * (2 ** bank_aw);

  int fail_count = 0;

  // Word that the image holds at a fetch address.
  function automatic boot_rom_pkg::word_t pattern_at(input boot_rom_pkg::cpu_addr_t a);
    pattern_at = boot_rom_pkg::word_t'(a % img_words) ^ 16'hC3A5;
  endfunction

  reset_state_a: assert property (@(posedge clk)
    rst |=> !ready && spi_cs && spi_sclk && instruction == '0)
    else begin $error("Outputs are not in their reset state after reset."); fail_count++; end

  zero_while_loading_a: assert property (@(posedge clk) disable iff (rst)
    !ready |-> instruction == '0)
    else begin $error("Instruction is not zero while the copy runs."); fail_count++; end

  ready_holds_a: assert property (@(posedge clk) disable iff (rst) ready |=> ready)
    else begin $error("Ready fell after the copy had finished."); fail_count++; end

  flash_idle_a: assert property (@(posedge clk) disable iff (rst) ready |-> spi_cs && spi_sclk)
    else begin $error("The flash interface is active after the copy."); fail_count++; end

  // One cycle of read latency, counted once the banks belong to the processor.
  read_data_a: assert property (@(posedge clk) disable iff (rst)
    ready && $past(ready) |-> instruction == pattern_at($past(address)))
    else begin $error("Instruction does not match the image word."); fail_count++; end

endmodule

// File: verif/spi_flash_model.sv
`timescale 1ns/1ps
`include "boot_rom_config.svh"

module spi_flash_model (
  input  logic spi_cs,
  input  logic spi_sclk,
  input  logic spi_mosi,
  output logic spi_miso,
  output int   cmd_count,
  output int   cmd_errors
);

  boot_rom_pkg::flash_addr_t next_addr = `BOOT_ROM_FLASH_BASE;  // Address the next READ must carry.
  boot_rom_pkg::word_t       data_word = '0;
  logic [31:0]               cmd_bits  = '0;
  int                        rx_cnt    = 0;  // Rising sclk edges seen in this command.
  int                        cmds      = 0;
  int                        errors    = 0;
  logic                      miso_q    = 1'b0;

  assign spi_miso   = miso_q;
  assign cmd_count  = cmds;
  assign cmd_errors = errors;

  // Image word stored at a byte address, high byte first in the flash.
  function automatic boot_rom_pkg::word_t pattern_word(input boot_rom_pkg::flash_addr_t byte_addr);
    boot_rom_pkg::flash_addr_t offset;
    offset       = byte_addr - `BOOT_ROM_FLASH_BASE;
    pattern_word = boot_rom_pkg::word_t'(offset >> 1) ^ 16'hC3A5;
  endfunction

  task automatic check_command(input logic [31:0] cmd);
    boot_rom_pkg::flash_addr_t cmd_addr;
    cmd_addr = cmd[23:0];
    opcode_ok_a: assert (cmd[31:24] == `BOOT_ROM_READ_OP) else begin
      $display("mismatch at %0t ns: flash opcode expected %h, got %h",
               $time, `BOOT_ROM_READ_OP, cmd[31:24]);
      errors++;
    end
    address_ok_a: assert (cmd_addr == next_addr) else begin
      $display("mismatch at %0t ns: flash address expected %h, got %h",
               $time, next_addr, cmd_addr);
      errors++;
    end
    data_word = pattern_word(cmd_addr);
    next_addr = cmd_addr + 24'd2;  // Each command fetches the following word.
    cmds++;
  endtask

  // Command bits arrive on the rising sclk, cs going high ends the command.
  always @(posedge spi_sclk or posedge spi_cs) begin
    logic [31:0] full_cmd;
    full_cmd = {cmd_bits[30:0], spi_mosi};
    if (spi_cs) begin
      rx_cnt = 0;
    end else begin
      cmd_bits = full_cmd;
      rx_cnt   = rx_cnt + 1;
      if (rx_cnt == 32) begin
        check_command(full_cmd);  // Opcode and the three address bytes are in.
      end
    end
  end

  // Data goes out on the falling sclk, so it is stable when the reader samples it.
  always @(negedge spi_sclk) begin
    logic [3:0] bit_idx;
    bit_idx = 4'(47 - rx_cnt);
    if (!spi_cs && rx_cnt >= 32 && rx_cnt < 48) begin
      miso_q <= data_word[bit_idx];
    end
  end

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns = 40
) (
  output logic clk
);

  localparam int half_period = period_ns / 2;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;  // Free-running, the testbench ends the run.
  end

endmodule

// File: rtl/boot_rom.sv
`timescale 1ns/1ps
`include "boot_rom_config.svh"

module boot_rom #(
  parameter int bank_aw = `BOOT_ROM_BANK_AW
) (
  input  logic                    clk,
  input  logic                    rst,
  input  boot_rom_pkg::cpu_addr_t address,
  output boot_rom_pkg::word_t     instruction,
  output logic                    ready,
  input  logic                    spi_miso,
  output logic                    spi_cs,
  output logic                    spi_sclk,
  output logic                    spi_mosi
);

  logic                      fetch_en;
  boot_rom_pkg::flash_addr_t flash_addr;
  logic                      word_valid;
  boot_rom_pkg::word_t       flash_word;

  logic [bank_aw-1:0]        bank_addr;   // Shared by both banks.
  boot_rom_pkg::word_t       wdata;
  logic                      we;
  logic                      cs_lo;
  logic                      cs_hi;
  boot_rom_pkg::word_t       rdata_lo;
  boot_rom_pkg::word_t       rdata_hi;

  spi_flash_reader reader_i (
    .clk        (clk),
    .rst        (rst),
    .fetch_en   (fetch_en),
    .flash_addr (flash_addr),
    .word_valid (word_valid),
    .flash_word (flash_word),
    .spi_cs     (spi_cs),
    .spi_sclk   (spi_sclk),
    .spi_mosi   (spi_mosi),
    .spi_miso   (spi_miso)
  );

  // Lower half of the image.
  spram_bank #(.bank_aw(bank_aw)) bank_lo_i (
    .clk   (clk),
    .cs    (cs_lo),
    .we    (we),
    .addr  (bank_addr),
    .wdata (wdata),
    .rdata (rdata_lo)
  );

  // Upper half of the image.
  spram_bank #(.bank_aw(bank_aw)) bank_hi_i (
    .clk   (clk),
    .cs    (cs_hi),
    .we    (we),
    .addr  (bank_addr),
    .wdata (wdata),
    .rdata (rdata_hi)
  );

  rom_bank_ctrl #(.bank_aw(bank_aw)) ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .address     (address),
    .instruction (instruction),
    .ready       (ready),
    .fetch_en    (fetch_en),
    .flash_addr  (flash_addr),
    .word_valid  (word_valid),
    .flash_word  (flash_word),
    .bank_addr   (bank_addr),
    .wdata       (wdata),
    .we          (we),
    .cs_lo       (cs_lo),
    .cs_hi       (cs_hi),
    .rdata_lo    (rdata_lo),
    .rdata_hi    (rdata_hi)
  );

endmodule

// File: rtl/rom_bank_ctrl.sv
`timescale 1ns/1ps
`include "boot_rom_config.svh"

module rom_bank_ctrl #(
  parameter int bank_aw = `BOOT_ROM_BANK_AW
) (
  input  logic                      clk,
  input  logic                      rst,
  input  boot_rom_pkg::cpu_addr_t   address,
  output boot_rom_pkg::word_t       instruction,
  output logic                      ready,
  output logic                      fetch_en,
  output boot_rom_pkg::flash_addr_t flash_addr,
  input  logic                      word_valid,
  input  boot_rom_pkg::word_t       flash_word,
  output logic [bank_aw-1:0]        bank_addr,
  output boot_rom_pkg::word_t       wdata,
  output logic                      we,
  output logic                      cs_lo,
  output logic                      cs_hi,
  input  boot_rom_pkg::word_t       rdata_lo,
  input  boot_rom_pkg::word_t       rdata_hi
);

  localparam int idx_w = bank_aw + 2;  // One spare bit so the index can reach the image size.
  localparam logic [idx_w-1:0] img_words = idx_w'(2) << bank_aw;

  logic [idx_w-1:0] wr_idx;    // Words copied so far.
  logic             loading;
  logic             sel_now;   // Bank picked for this cycle's access.
  logic             sel_q;     // Bank whose read data arrives this cycle.

  assign loading  = wr_idx < img_words;
  assign ready    = !loading;
  assign fetch_en = loading;  // Dropping this parks the flash interface.

  // Two bytes per word, so the byte offset is the index shifted by one.
  assign flash_addr = `BOOT_ROM_FLASH_BASE +
                      boot_rom_pkg::flash_addr_t'({wr_idx[bank_aw:0], 1'b0});

  // The copy owns the banks until the image is complete.
  assign sel_now   = loading ? wr_idx[bank_aw] : address[bank_aw];
  assign bank_addr = loading ? wr_idx[bank_aw-1:0] : address[bank_aw-1:0];
  assign cs_lo     = !sel_now;
  assign cs_hi     = sel_now;

  assign wdata = flash_word;
  assign we    = loading && word_valid;

  // Match the bank read latency with the select from the previous cycle.
  assign instruction = loading ? '0 : (sel_q ? rdata_hi : rdata_lo);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_idx <= '0;
      sel_q  <= 1'b0;
    end else begin
      if (we) begin
        wr_idx <= wr_idx + idx_w'(1);
      end
      sel_q <= sel_now;
    end
  end

endmodule

// File: rtl/spram_bank.sv
`timescale 1ns/1ps
`include "boot_rom_config.svh"

module spram_bank #(
  parameter int bank_aw = `BOOT_ROM_BANK_AW
) (
  input  logic                clk,
  input  logic                cs,
  input  logic                we,
  input  logic [bank_aw-1:0]  addr,
  input  boot_rom_pkg::word_t wdata,
  output boot_rom_pkg::word_t rdata
);

  localparam int depth = 2 ** bank_aw;

  boot_rom_pkg::word_t mem [depth];

  // A selected cycle either writes or reads, never both.
  always_ff @(posedge clk) begin
    if (cs) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];  // Data shows up on the edge after the address.
      end
    end
    // rdata keeps its last value while the bank is deselected.
  end

endmodule

// File: rtl/spi_flash_reader.sv
`timescale 1ns/1ps
`include "boot_rom_config.svh"

module spi_flash_reader (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      fetch_en,
  input  boot_rom_pkg::flash_addr_t flash_addr,
  output logic                      word_valid,
  output boot_rom_pkg::word_t       flash_word,
  output logic                      spi_cs,
  output logic                      spi_sclk,
  output logic                      spi_mosi,
  input  logic                      spi_miso
);

  // One step per byte on the wire, plus a final step that hands out the word.
  localparam logic [2:0] st_opcode   = 3'd0;
  localparam logic [2:0] st_addr_hi  = 3'd1;
  localparam logic [2:0] st_addr_mid = 3'd2;
  localparam logic [2:0] st_addr_lo  = 3'd3;
  localparam logic [2:0] st_data_hi  = 3'd4;
  localparam logic [2:0] st_data_lo  = 3'd5;
  localparam logic [2:0] st_done     = 3'd6;

  logic [7:0] shift_buf;  // Outgoing bits leave at the top, incoming enter at the bottom.
  logic [3:0] bit_cnt;    // Bits still to move in the current byte.
  logic [2:0] state;

  always_ff @(posedge clk) begin
    word_valid <= 1'b0;  // Pulse lasts a single cycle.

    // The cycle after a word goes out, cs returns high so every word gets its own command.
    if (rst || word_valid || !fetch_en) begin
      spi_cs   <= 1'b1;
      spi_sclk <= 1'b1;  // Clock parks high between commands.
      spi_mosi <= 1'b0;
      bit_cnt  <= 4'd0;
      state    <= st_opcode;
    end else begin
      spi_cs <= 1'b0;

      if (bit_cnt != 4'd0) begin
        if (spi_sclk) begin
          spi_sclk <= 1'b0;
          spi_mosi <= shift_buf[7];  // Launch on the falling edge.
        end else begin
          spi_sclk  <= 1'b1;
          shift_buf <= {shift_buf[6:0], spi_miso};  // Flash data is valid at the rising edge.
          bit_cnt   <= bit_cnt - 4'd1;
        end
      end else begin
        // Setup cycle between bytes.
        case (state)
          st_opcode: begin
            shift_buf <= `BOOT_ROM_READ_OP;
            bit_cnt   <= 4'd8;
            state     <= st_addr_hi;
          end
          st_addr_hi: begin
            shift_buf <= flash_addr[23:16];
            bit_cnt   <= 4'd8;
            state     <= st_addr_mid;
          end
          st_addr_mid: begin
            shift_buf <= flash_addr[15:8];
            bit_cnt   <= 4'd8;
            state     <= st_addr_lo;
          end
          st_addr_lo: begin
            shift_buf <= flash_addr[7:0];
            bit_cnt   <= 4'd8;
            state     <= st_data_hi;
          end
          st_data_hi: begin
            shift_buf <= 8'h00;  // Keeps mosi low while the flash talks.
            bit_cnt   <= 4'd8;
            state     <= st_data_lo;
          end
          st_data_lo: begin
            flash_word[15:8] <= shift_buf;  // High byte comes first.
            bit_cnt          <= 4'd8;
            state            <= st_done;
          end
          st_done: begin
            flash_word[7:0] <= shift_buf;
            word_valid      <= 1'b1;
          end
          default: begin
            state <= st_opcode;
          end
        endcase
      end
    end
  end

endmodule

// File: rtl/boot_rom_pkg.sv
package boot_rom_pkg;

  // Instruction word, also the unit fetched from the flash.
  typedef logic [15:0] word_t;

  // Byte address on the SPI flash.
  typedef logic [23:0] flash_addr_t;

  // Processor fetch address, in words.
  typedef logic [15:0] cpu_addr_t;

endpackage

// File: rtl/boot_rom_config.svh
`ifndef BOOT_ROM_CONFIG_SVH
`define BOOT_ROM_CONFIG_SVH

// Byte address of the boot image inside the SPI NOR flash.
`define BOOT_ROM_FLASH_BASE 24'h100000

// Default bank address width.
// 14 bits give 16K words per bank and a 32K-word image over both banks.
`define BOOT_ROM_BANK_AW 14

// SPI NOR READ command.
// It takes a 24-bit byte address and has no dummy cycles.
`define BOOT_ROM_READ_OP 8'h03

`endif
